// ==== hdl/cart_pkg.sv ====
package cart_pkg;

    ////////////////////
    // Mapper codes
    ////////////////////
    typedef enum logic [2:0] {
        MAP_HIROM      = 3'b000,
        MAP_LOROM      = 3'b001,
        MAP_EXHIROM    = 3'b010,   // 48-64 Mbit
        MAP_BSX        = 3'b011,
        MAP_INTERLEAVE = 3'b110,   // 96 Mbit interleaved layout
        MAP_MENU       = 3'b111    // Menu ROM sits in upper SRAM
    } mapper_t;

    // Cartridge setup as written by the MCU
    typedef struct packed {
        mapper_t     mapper;
        logic [23:0] rom_mask;
        logic [23:0] saveram_mask;
        logic        use_msu;
    } cart_cfg_t;

    // Console address phase
    typedef struct packed {
        logic [23:0] addr;
        logic        cs_n;       // CART pin, active low
        logic        wr_n;
        logic [7:0]  data;
    } snes_req_t;

    // Decoded SRAM request
    typedef struct packed {
        logic [22:0] rom_addr;     // SRAM word address
        logic        rom_addr0;    // Byte select
        logic        is_rom;
        logic        is_saveram;
        logic        is_writable;
        logic        msu_enable;
        logic        from_mcu;     // Set on MCU bus phase
    } addr_result_t;

    ////////////////////
    // BS-X registers
    ////////////////////
    localparam int BSX_REG_W     = 15;
    localparam int BSX_PRAM      = 1;   // PRAM instead of flash in ROM area
    localparam int BSX_HIROM     = 2;
    localparam int BSX_MIRROR_60 = 3;   // PRAM mirror at 60-6F
    localparam int BSX_NO_MIR_40 = 5;
    localparam int BSX_NO_MIR_50 = 6;
    localparam int BSX_CART_LO   = 7;   // Cart ROM at 00-1F:8000-FFFF
    localparam int BSX_CART_HI   = 8;   // Cart ROM at 80-9F:8000-FFFF

    // Config byte indices
    localparam logic [2:0] CFG_MAPPER    = 3'd0;
    localparam logic [2:0] CFG_ROM_MASK0 = 3'd1;
    localparam logic [2:0] CFG_ROM_MASK1 = 3'd2;
    localparam logic [2:0] CFG_ROM_MASK2 = 3'd3;
    localparam logic [2:0] CFG_SRAM_MASK0 = 3'd4;
    localparam logic [2:0] CFG_SRAM_MASK1 = 3'd5;
    localparam logic [2:0] CFG_SRAM_MASK2 = 3'd6;
    localparam logic [2:0] CFG_MSU       = 3'd7;

    localparam logic [23:0] SAVERAM_BASE      = 24'hE00000;
    localparam logic [23:0] MENU_SAVERAM_BASE = 24'hFF0000;

endpackage

// ==== hdl/address.sv ====
`timescale 1ns/100ps

module address import cart_pkg::*; (
    input  logic                 clk,     // Check clock, assertions only
    input  cart_cfg_t            cfg,
    input  logic [BSX_REG_W-1:0] bsx,
    input  snes_req_t            req,
    output addr_result_t         res
);

    localparam logic [23:0] BSX_PRAM_BASE = 24'h400000;
    localparam logic [23:0] BSX_CART_BASE = 24'h800000;
    localparam logic [23:0] MENU_ROM_BASE = 24'hE00000;  // Menu image in upper SRAM

    logic [23:0] a;
    logic [14:0] hi_sram_off;        // Offset from 6000 in HiROM-style window
    logic        hirom_like;
    logic        map_known;
    logic        hi_sram_win;
    logic        lo_sram_win;
    logic        bsx_sram_win;
    logic        bsx_pram_win;
    logic        bsx_cart;
    logic [23:0] bsx_rom_base;
    logic [23:0] bsx_rom_mask;
    logic        is_rom;
    logic        is_saveram;
    logic        is_writable;
    logic        msu_enable;
    logic [23:0] full_addr;

    assign a           = req.addr;
    assign hi_sram_off = a[14:0] - 15'h6000;

    assign hirom_like = cfg.mapper inside {MAP_HIROM, MAP_EXHIROM, MAP_INTERLEAVE, MAP_MENU};
    assign map_known  = hirom_like || cfg.mapper inside {MAP_LOROM, MAP_BSX};

    ////////////////////
    // Region windows
    ////////////////////
    // Banks 30-3F / B0-BF, 6000-7FFF
    assign hi_sram_win = !a[22] && (&a[21:20]) && !a[15] && (&a[14:13]) && req.cs_n;
    // Banks 70-7D / F0-FD, 0000-7FFF
    assign lo_sram_win = (&a[22:20]) && (a[19:16] < 4'hE) && !a[15] && !req.cs_n;
    assign bsx_sram_win = (a[23:19] == 5'b00010) && (a[15:12] == 4'h5);   // 10-17:5xxx

    // PRAM mirrors, each under its own register bit
    assign bsx_pram_win = (bsx[BSX_MIRROR_60] && a[23:20] == 4'h6)
                       || (!bsx[BSX_NO_MIR_40] && a[23:20] == 4'h4)
                       || (!bsx[BSX_NO_MIR_50] && a[23:20] == 4'h5)
                       || (a[23:19] == 5'b01110)                          // 70-77
                       || (a[23:21] == 3'b001 && a[15:13] == 3'b011);    // 20-3F:6000-7FFF

    assign bsx_cart = (bsx[BSX_CART_LO] && a[23:21] == 3'b000)
                   || (bsx[BSX_CART_HI] && a[23:21] == 3'b100);

    // Flash or PRAM image; PRAM half is half the size
    assign bsx_rom_base = bsx[BSX_PRAM] ? BSX_PRAM_BASE : 24'h000000;
    assign bsx_rom_mask = cfg.rom_mask >> bsx[BSX_PRAM];

    ////////////////////
    // Classification
    ////////////////////
    assign is_rom = map_known && (a[22] || a[15]);   // Same rule for all mappers

    always_comb begin
        is_saveram = 1'b0;
        if (hirom_like) begin
            is_saveram = hi_sram_win;
        end else if (cfg.mapper == MAP_LOROM) begin
            is_saveram = lo_sram_win;
        end else if (cfg.mapper == MAP_BSX) begin
            is_saveram = bsx_sram_win;
        end
    end

    assign is_writable = is_saveram || (cfg.mapper == MAP_BSX && bsx_pram_win);

    // MSU regs at 2000-2007 in system banks
    assign msu_enable = cfg.use_msu && !a[22] && ((a[15:0] & 16'hFFF8) == 16'h2000);

    ////////////////////
    // Translation
    ////////////////////
    always_comb begin
        full_addr = 24'h000000;
        case (cfg.mapper)
            MAP_HIROM: begin
                full_addr = is_saveram
                    ? SAVERAM_BASE + ({9'h0, hi_sram_off} & cfg.saveram_mask)
                    : {1'b0, a[22:0]} & cfg.rom_mask;
            end
            MAP_LOROM: begin
                full_addr = is_saveram
                    ? SAVERAM_BASE + ({9'h0, a[14:0]} & cfg.saveram_mask)
                    : {2'b00, a[22:16], a[14:0]} & cfg.rom_mask;   // Drop A15
            end
            MAP_EXHIROM: begin
                full_addr = is_saveram
                    ? SAVERAM_BASE + ({9'h0, hi_sram_off} & cfg.saveram_mask)
                    : {1'b0, !a[23], a[21:0]} & cfg.rom_mask;      // Upper 32 Mbit in 00-7F
            end
            MAP_BSX: begin
                if (is_saveram) begin
                    full_addr = SAVERAM_BASE + {9'h0, a[18:16], a[11:0]};
                end else if (is_writable) begin
                    full_addr = BSX_PRAM_BASE + (a & 24'h07FFFF);  // 512K PRAM
                end else if (bsx_cart) begin
                    full_addr = BSX_CART_BASE + ({1'b0, a[23:16], a[14:0]} & 24'h0FFFFF);
                end else if (bsx[BSX_HIROM]) begin
                    full_addr = bsx_rom_base + ({2'b00, a[21:0]} & bsx_rom_mask);
                end else begin
                    full_addr = bsx_rom_base + ({1'b0, a[23:16], a[14:0]} & bsx_rom_mask);
                end
            end
            MAP_INTERLEAVE: begin
                if (is_saveram) begin
                    full_addr = SAVERAM_BASE + ({9'h0, hi_sram_off} & cfg.saveram_mask);
                end else if (a[15]) begin
                    full_addr = {1'b0, a[23:16], a[14:0]};           // Upper halves first
                end else begin
                    full_addr = {2'b10, a[23], a[21:16], a[14:0]};   // Lower halves above 8M
                end
            end
            MAP_MENU: begin
                full_addr = is_saveram
                    ? MENU_SAVERAM_BASE + ({9'h0, hi_sram_off} & cfg.saveram_mask)
                    : ({1'b0, a[22:0]} & cfg.rom_mask) + MENU_ROM_BASE;
            end
            default: full_addr = 24'h000000;   // No region
        endcase
    end

    assign res = '{
        rom_addr:    full_addr[23:1],
        rom_addr0:   full_addr[0],
        is_rom:      is_rom,
        is_saveram:  is_saveram,
        is_writable: is_writable,
        msu_enable:  msu_enable,
        from_mcu:    1'b0
    };

    // Save RAM must always be write-enabled downstream
    a_saveram_writable : assert property (@(posedge clk) res.is_saveram |-> res.is_writable);

endmodule

// ==== hdl/bsx_regs.sv ====
`timescale 1ns/100ps

module bsx_regs import cart_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  cart_cfg_t            cfg,
    input  snes_req_t            req,
    input  logic                 strobe,     // Console address phase valid
    output logic [BSX_REG_W-1:0] bsx,
    output logic                 use_bsx
);

    logic       is_bsx;
    logic       reg_win;     // 01-0F:5000 register window
    logic [3:0] reg_idx;
    logic       reg_wr;

    assign is_bsx  = (cfg.mapper == MAP_BSX);
    assign reg_idx = req.addr[19:16];

    assign reg_win = (req.addr[23:20] == 4'h0)
                  && (reg_idx != 4'h0)
                  && (req.addr[15:0] == 16'h5000);

    // Bank 0F has no bit behind it
    assign reg_wr = strobe && !req.wr_n && is_bsx && reg_win
                 && (32'(reg_idx) < BSX_REG_W);

    ////////////////////
    // Register bits
    ////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bsx     <= '0;
            use_bsx <= 1'b0;
        end else begin
            use_bsx <= is_bsx;
            if (reg_wr) begin
                bsx[reg_idx] <= req.data[7];   // One bit per register, D7
            end
        end
    end

    // Register file frozen outside BS-X mode
    a_bsx_frozen : assert property (
        @(posedge clk) disable iff (!rst_n)
        !is_bsx |=> $stable(bsx)
    );

endmodule

// ==== hdl/mcu_cfg.sv ====
`timescale 1ns/100ps

module mcu_cfg import cart_pkg::*; #(
    parameter mapper_t RESET_MAPPER = MAP_MENU
) (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      cfg_wr,      // Byte strobe from MCU
    input  logic [2:0] cfg_sel,
    input  logic [7:0] cfg_data,
    output cart_cfg_t cfg
);

    cart_cfg_t cfg_q;

    ////////////////////
    // Config registers
    ////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cfg_q.mapper       <= RESET_MAPPER;
            cfg_q.rom_mask     <= '1;   // Full range until MCU sizes it
            cfg_q.saveram_mask <= '1;
            cfg_q.use_msu      <= 1'b0;
        end else if (cfg_wr) begin
            case (cfg_sel)
                CFG_MAPPER: begin
                    cfg_q.mapper <= mapper_t'(cfg_data[2:0]);   // Unlisted codes decode as no region
                end
                // ROM mask, low byte first
                CFG_ROM_MASK0: begin
                    cfg_q.rom_mask[7:0] <= cfg_data;
                end
                CFG_ROM_MASK1: begin
                    cfg_q.rom_mask[15:8] <= cfg_data;
                end
                CFG_ROM_MASK2: begin
                    cfg_q.rom_mask[23:16] <= cfg_data;
                end
                // Save RAM mask
                CFG_SRAM_MASK0: begin
                    cfg_q.saveram_mask[7:0] <= cfg_data;
                end
                CFG_SRAM_MASK1: begin
                    cfg_q.saveram_mask[15:8] <= cfg_data;
                end
                CFG_SRAM_MASK2: begin
                    cfg_q.saveram_mask[23:16] <= cfg_data;
                end
                CFG_MSU: begin
                    cfg_q.use_msu <= cfg_data[0];
                end
            endcase
        end
    end

    assign cfg = cfg_q;

    // Byte select must be clean on every write
    a_sel_known : assert property (
        @(posedge clk) disable iff (!rst_n)
        cfg_wr |-> !$isunknown(cfg_sel)
    );

endmodule

// ==== hdl/mem_port.sv ====
`timescale 1ns/100ps

module mem_port import cart_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         snes_strobe,    // Console address phase, 1-cycle pulse
    input  addr_result_t snes_res,
    input  logic         mcu_strobe,     // MCU request, 1-cycle pulse
    input  logic [23:0]  mcu_addr,
    output addr_result_t result,
    output logic         res_valid,
    output logic         mcu_busy
);

    logic        mcu_pend;        // MCU request held back by console
    logic [23:0] mcu_pend_addr;
    logic [23:0] mcu_src;
    logic        mcu_req;         // MCU request ready to issue
    logic        mcu_defer;

    // MCU phase passes the address straight through, no flags
    function automatic addr_result_t mcu_result(input logic [23:0] addr);
        addr_result_t r;
        r           = '0;
        r.rom_addr  = addr[23:1];
        r.rom_addr0 = addr[0];
        r.from_mcu  = 1'b1;
        return r;
    endfunction

    assign mcu_req   = mcu_pend || mcu_strobe;
    assign mcu_src   = mcu_pend ? mcu_pend_addr : mcu_addr;   // Pending entry is older
    assign mcu_defer = snes_strobe && mcu_req;                // Console always wins

    ////////////////////
    // Pending MCU slot
    ////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mcu_pend <= 1'b0;
        end else begin
            mcu_pend <= mcu_defer;
        end
    end

    always_ff @(posedge clk) begin
        if (mcu_defer) begin
            mcu_pend_addr <= mcu_src;
        end
    end

    ////////////////////
    // Output register
    ////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= snes_strobe || mcu_req;
        end
    end

    always_ff @(posedge clk) begin
        if (snes_strobe) begin
            result <= snes_res;             // Decoder already clears from_mcu
        end else if (mcu_req) begin
            result <= mcu_result(mcu_src);
        end
    end

    assign mcu_busy = mcu_pend;

    // MCU holds off while its last request waits
    a_no_mcu_while_busy : assert property (
        @(posedge clk) disable iff (!rst_n)
        mcu_busy |-> !mcu_strobe
    );

    // Every strobe is answered within two cycles
    a_strobe_served : assert property (
        @(posedge clk) disable iff (!rst_n)
        (snes_strobe || mcu_strobe) |-> ##[1:2] res_valid
    );

endmodule

// ==== hdl/cart_top.sv ====
`timescale 1ns/100ps

module cart_top import cart_pkg::*; #(
    parameter mapper_t RESET_MAPPER = MAP_MENU
) (
    input  logic         clk,
    input  logic         rst_n,
    // Console bus
    input  snes_req_t    snes_req,
    input  logic         snes_strobe,
    // MCU side
    input  logic [23:0]  mcu_addr,
    input  logic         mcu_strobe,
    input  logic         cfg_wr,
    input  logic [2:0]   cfg_sel,
    input  logic [7:0]   cfg_data,
    // SRAM request
    output addr_result_t result,
    output logic         res_valid,
    output logic         mcu_busy,
    output logic         use_bsx
);

    cart_cfg_t            cfg;
    logic [BSX_REG_W-1:0] bsx;
    addr_result_t         snes_res;   // Combinational console decode

    mcu_cfg #(
        .RESET_MAPPER(RESET_MAPPER)
    ) u_mcu_cfg (
        .clk     (clk),
        .rst_n   (rst_n),
        .cfg_wr  (cfg_wr),
        .cfg_sel (cfg_sel),
        .cfg_data(cfg_data),
        .cfg     (cfg)
    );

    bsx_regs u_bsx_regs (
        .clk    (clk),
        .rst_n  (rst_n),
        .cfg    (cfg),
        .req    (snes_req),
        .strobe (snes_strobe),
        .bsx    (bsx),
        .use_bsx(use_bsx)
    );

    address u_address (
        .clk(clk),
        .cfg(cfg),
        .bsx(bsx),
        .req(snes_req),
        .res(snes_res)
    );

    mem_port u_mem_port (
        .clk        (clk),
        .rst_n      (rst_n),
        .snes_strobe(snes_strobe),
        .snes_res   (snes_res),
        .mcu_strobe (mcu_strobe),
        .mcu_addr   (mcu_addr),
        .result     (result),
        .res_valid  (res_valid),
        .mcu_busy   (mcu_busy)
    );

endmodule

// ==== verification/cart_tb.sv ====
`timescale 1ns/100ps

module cart_tb import cart_pkg::*; ();

    localparam int MAX_CYCLES = 6000;   // ~1500 requests, up to 3 cycles each, with margin
    localparam snes_req_t IDLE_REQ = '{addr: 24'h0, cs_n: 1'b1, wr_n: 1'b1, data: 8'h0};

    logic         clk;
    logic         rst_n;
    snes_req_t    snes_req;
    logic         snes_strobe;
    logic [23:0]  mcu_addr;
    logic         mcu_strobe;
    logic         cfg_wr;
    logic [2:0]   cfg_sel;
    logic [7:0]   cfg_data;
    addr_result_t result;
    logic         res_valid;
    logic         mcu_busy;
    logic         use_bsx;

    integer               seed = 32'h37cf_6d6b;
    int                   err_val = 0;     // Wrong values
    int                   err_seq = 0;     // Missing or extra results
    int                   cycles = 0;
    addr_result_t         exp_q[$];        // Expected results in issue order
    cart_cfg_t            mcfg;            // Model of the MCU config
    logic [BSX_REG_W-1:0] mbsx;            // Model of the BS-X bits
    logic                 pend;            // Model of the held MCU request
    logic [23:0]          paddr;
    logic                 use_bsx_exp;

    cart_top #(
        .RESET_MAPPER(MAP_MENU)
    ) UUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .snes_req   (snes_req),
        .snes_strobe(snes_strobe),
        .mcu_addr   (mcu_addr),
        .mcu_strobe (mcu_strobe),
        .cfg_wr     (cfg_wr),
        .cfg_sel    (cfg_sel),
        .cfg_data   (cfg_data),
        .result     (result),
        .res_valid  (res_valid),
        .mcu_busy   (mcu_busy),
        .use_bsx    (use_bsx)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;   // 50 MHz
    end

    ////////////////////
    // Reference mapping
    ////////////////////
    function automatic addr_result_t map_ref(input cart_cfg_t c, input logic [14:0] b,
                                             input snes_req_t r);
        addr_result_t res;
        logic [7:0]   bank;
        logic [15:0]  off;
        logic [23:0]  sa;
        logic         hi;
        logic         sram;
        logic         pram;
        logic         cart;
        bank = r.addr[23:16];
        off  = r.addr[15:0];
        hi   = c.mapper == MAP_HIROM || c.mapper == MAP_EXHIROM
            || c.mapper == MAP_INTERLEAVE || c.mapper == MAP_MENU;
        sram = 1'b0;
        if (hi) begin
            sram = (bank & 8'h70) == 8'h30 && off >= 16'h6000 && off < 16'h8000 && r.cs_n;
        end else if (c.mapper == MAP_LOROM) begin
            sram = (bank & 8'h7F) >= 8'h70 && (bank & 8'h7F) <= 8'h7D
                && off < 16'h8000 && !r.cs_n;
        end else if (c.mapper == MAP_BSX) begin
            sram = bank >= 8'h10 && bank <= 8'h17 && off[15:12] == 4'h5;
        end
        pram = (b[3] && bank[7:4] == 4'h6) || (!b[5] && bank[7:4] == 4'h4)
            || (!b[6] && bank[7:4] == 4'h5) || (bank >= 8'h70 && bank <= 8'h77)
            || (bank >= 8'h20 && bank <= 8'h3F && off >= 16'h6000 && off < 16'h8000);
        cart = (b[7] && bank < 8'h20) || (b[8] && bank >= 8'h80 && bank < 8'hA0);
        res             = '0;
        res.is_rom      = (hi || c.mapper == MAP_LOROM || c.mapper == MAP_BSX)
                       && (bank[6] || off[15]);
        res.is_saveram  = sram;
        res.is_writable = sram || (c.mapper == MAP_BSX && pram);
        res.msu_enable  = c.use_msu && !bank[6] && off >= 16'h2000 && off <= 16'h2007;
        sa = 24'h0;
        if (sram && c.mapper == MAP_BSX) begin
            sa = SAVERAM_BASE + {9'h0, bank[2:0], off[11:0]};   // Unmasked
        end else if (sram && c.mapper == MAP_LOROM) begin
            sa = SAVERAM_BASE + ({9'h0, off[14:0]} & c.saveram_mask);
        end else if (sram) begin
            sa = (c.mapper == MAP_MENU ? MENU_SAVERAM_BASE : SAVERAM_BASE)
               + ({8'h0, off - 16'h6000} & c.saveram_mask);
        end else begin
            case (c.mapper)
                MAP_HIROM:   sa = r.addr & {1'b0, c.rom_mask[22:0]};
                MAP_LOROM:   sa = {2'b0, bank[6:0], off[14:0]} & c.rom_mask;
                MAP_EXHIROM: sa = {1'b0, ~bank[7], bank[5:0], off} & c.rom_mask;
                MAP_BSX: begin
                    if (pram) begin
                        sa = 24'h400000 + {5'h0, bank[2:0], off};
                    end else if (cart) begin
                        sa = 24'h800000 + {4'h0, bank[4:0], off[14:0]};
                    end else begin
                        // Flash at 0, PRAM image at 400000 with half the mask
                        sa = (b[1] ? 24'h400000 : 24'h0)
                           + ((b[2] ? {2'b0, bank[5:0], off} : {1'b0, bank, off[14:0]})
                              & (c.rom_mask >> b[1]));
                    end
                end
                MAP_INTERLEAVE: begin
                    sa = off[15] ? {1'b0, bank, off[14:0]}
                                 : {2'b10, bank[7], bank[5:0], off[14:0]};
                end
                MAP_MENU: sa = 24'hE00000 + (r.addr & {1'b0, c.rom_mask[22:0]});
                default:  sa = 24'h0;
            endcase
        end
        res.rom_addr  = sa[23:1];
        res.rom_addr0 = sa[0];
        return res;
    endfunction

    ////////////////////
    // Compare tasks
    ////////////////////
    task automatic check_result(input string name, input addr_result_t act,
                                input addr_result_t exp);
        if (act !== exp) begin
            err_val++;
            $display("Error at %0t ns: %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic check_level(input string name, input logic act, input logic exp);
        if (act !== exp) begin
            err_val++;
            $display("Error at %0t ns: %s expected %b actual %b", $time, name, exp, act);
        end
    endtask

    // One bus cycle: check levels, drive on the falling edge, update the model
    task automatic apply(input logic s_stb, input snes_req_t r, input logic m_stb,
                         input logic [23:0] ma, input logic c_wr, input logic [2:0] c_sel,
                         input logic [7:0] c_dat);
        addr_result_t e;
        logic         issue;
        @(negedge clk);
        check_level("mcu_busy", mcu_busy, pend);
        check_level("use_bsx", use_bsx, use_bsx_exp);
        use_bsx_exp = (mcfg.mapper == MAP_BSX);   // Flag lags config by a cycle
        snes_strobe = s_stb;
        snes_req    = r;
        mcu_strobe  = m_stb;
        mcu_addr    = ma;
        cfg_wr      = c_wr;
        cfg_sel     = c_sel;
        cfg_data    = c_dat;
        issue = s_stb || pend || m_stb;
        e = '0;
        if (s_stb) begin
            e = map_ref(mcfg, mbsx, r);
        end else begin
            e.rom_addr  = pend ? paddr[23:1] : ma[23:1];   // MCU passthrough
            e.rom_addr0 = pend ? paddr[0] : ma[0];
            e.from_mcu  = 1'b1;
        end
        if (s_stb && (pend || m_stb)) begin
            paddr = pend ? paddr : ma;   // Console wins, MCU waits
            pend  = 1'b1;
        end else begin
            pend = 1'b0;
        end
        if (s_stb && !r.wr_n && mcfg.mapper == MAP_BSX && r.addr[23:20] == 4'h0
                && r.addr[19:16] != 4'h0 && r.addr[15:0] == 16'h5000
                && r.addr[19:16] < BSX_REG_W) begin
            mbsx[r.addr[19:16]] = r.data[7];
        end
        if (c_wr) begin
            case (c_sel)
                CFG_MAPPER:     mcfg.mapper = mapper_t'(c_dat[2:0]);
                CFG_ROM_MASK0:  mcfg.rom_mask[7:0] = c_dat;
                CFG_ROM_MASK1:  mcfg.rom_mask[15:8] = c_dat;
                CFG_ROM_MASK2:  mcfg.rom_mask[23:16] = c_dat;
                CFG_SRAM_MASK0: mcfg.saveram_mask[7:0] = c_dat;
                CFG_SRAM_MASK1: mcfg.saveram_mask[15:8] = c_dat;
                CFG_SRAM_MASK2: mcfg.saveram_mask[23:16] = c_dat;
                default:        mcfg.use_msu = c_dat[0];
            endcase
        end
        @(posedge clk);
        if (issue) begin
            exp_q.push_back(e);
        end
    endtask

    task automatic console(input snes_req_t r);
        apply(1'b1, r, 1'b0, 24'h0, 1'b0, 3'd0, 8'h0);
    endtask

    task automatic idle(input int n);
        repeat (n) apply(1'b0, IDLE_REQ, 1'b0, 24'h0, 1'b0, 3'd0, 8'h0);
    endtask

    task automatic cfg_byte(input logic [2:0] sel, input logic [7:0] data);
        apply(1'b0, IDLE_REQ, 1'b0, 24'h0, 1'b1, sel, data);
    endtask

    task automatic write_cfg(input cart_cfg_t c);
        cfg_byte(CFG_MAPPER, {5'h0, c.mapper});
        cfg_byte(CFG_ROM_MASK0, c.rom_mask[7:0]);
        cfg_byte(CFG_ROM_MASK1, c.rom_mask[15:8]);
        cfg_byte(CFG_ROM_MASK2, c.rom_mask[23:16]);
        cfg_byte(CFG_SRAM_MASK0, c.saveram_mask[7:0]);
        cfg_byte(CFG_SRAM_MASK1, c.saveram_mask[15:8]);
        cfg_byte(CFG_SRAM_MASK2, c.saveram_mask[23:16]);
        cfg_byte(CFG_MSU, {7'h0, c.use_msu});
    endtask

    task automatic bsx_write(input logic [3:0] idx, input logic val);
        console('{addr: {4'h0, idx, 16'h5000}, cs_n: 1'b0, wr_n: 1'b0, data: {val, 7'h0}});
    endtask

    function automatic cart_cfg_t rand_cfg(input mapper_t m, input logic msu);
        cart_cfg_t c;
        c.mapper       = m;
        c.rom_mask     = 24'hFFFFFF >> ($random(seed) & 7);   // Power-of-two ROM sizes
        c.saveram_mask = $random(seed);
        c.use_msu      = msu;
        return c;
    endfunction

    // Random address, biased toward the save RAM, MSU and BS-X windows
    function automatic snes_req_t rand_req();
        snes_req_t   r;
        logic [31:0] v;
        v      = $random(seed);
        r.addr = v[23:0];
        r.cs_n = v[24];
        r.wr_n = v[25];
        r.data = $random(seed);
        case (v[28:26])
            3'd0: begin
                r.addr[22:20] = 3'b011;
                r.addr[15:13] = 3'b011;
            end
            3'd1: begin
                r.addr[22:20] = 3'b111;
                r.addr[15]    = 1'b0;
            end
            3'd2: r.addr[15:3] = 13'h0400;   // 2000-2007
            3'd3: begin
                r.addr[23:19] = 5'b00010;
                r.addr[15:12] = 4'h5;
            end
            default: ;
        endcase
        return r;
    endfunction

    task automatic run_random(input int n);
        repeat (n) console(rand_req());
    endtask

    ////////////////////
    // Result checker
    ////////////////////
    always @(negedge clk) begin
        if (rst_n && res_valid) begin
            if (exp_q.size() == 0) begin
                err_seq++;
                $display("Result at %0t ns arrived with no request outstanding", $time);
            end else begin
                check_result("result", result, exp_q.pop_front());
            end
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Run stopped after %0d cycles without finishing", cycles);
            $display("TEST FAIL");
            $finish;
        end
    end

    ////////////////////
    // Stimulus
    ////////////////////
    initial begin
        int i;
        rst_n       = 1'b0;
        snes_req    = IDLE_REQ;
        snes_strobe = 1'b0;
        mcu_addr    = 24'h0;
        mcu_strobe  = 1'b0;
        cfg_wr      = 1'b0;
        cfg_sel     = 3'd0;
        cfg_data    = 8'h0;
        mcfg        = '{mapper: MAP_MENU, rom_mask: '1, saveram_mask: '1, use_msu: 1'b0};
        mbsx        = '0;
        pend        = 1'b0;
        paddr       = 24'h0;
        use_bsx_exp = 1'b0;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;

        run_random(40);                          // Menu mapper straight from reset
        write_cfg(rand_cfg(MAP_HIROM, 1'b0));
        run_random(120);
        write_cfg(rand_cfg(MAP_LOROM, 1'b0));
        run_random(120);
        write_cfg(rand_cfg(MAP_EXHIROM, 1'b0));
        run_random(120);
        write_cfg(rand_cfg(MAP_INTERLEAVE, 1'b0));
        run_random(120);
        write_cfg(rand_cfg(MAP_MENU, 1'b0));
        run_random(120);
        write_cfg(rand_cfg(mapper_t'(3'd4), 1'b0));   // Unlisted code, no region
        run_random(20);

        // BS-X bits, then decode under them
        write_cfg(rand_cfg(MAP_BSX, 1'b0));
        repeat (4) begin
            for (i = 1; i < 16; i++) bsx_write(i[3:0], $random(seed));
            run_random(80);
        end
        write_cfg(rand_cfg(MAP_HIROM, 1'b0));
        for (i = 1; i < 16; i++) bsx_write(i[3:0], $random(seed));   // Must be ignored
        write_cfg(rand_cfg(MAP_BSX, 1'b0));
        run_random(60);

        repeat (100) apply(1'b0, IDLE_REQ, 1'b1, $random(seed), 1'b0, 3'd0, 8'h0);

        // Collisions, sometimes with a second console strobe right after
        repeat (50) begin
            apply(1'b1, rand_req(), 1'b1, $random(seed), 1'b0, 3'd0, 8'h0);
            if ($random(seed) & 1) console(rand_req());
            else idle(1);
            idle(1);
        end

        write_cfg(rand_cfg(MAP_HIROM, 1'b0));
        run_random(80);
        write_cfg(rand_cfg(MAP_HIROM, 1'b1));   // MSU window on
        run_random(80);

        idle(4);
        if (exp_q.size() != 0) begin
            err_seq++;
            $display("%0d expected results never came back", exp_q.size());
        end
        $display("Errors: %0d value, %0d sequence", err_val, err_seq);
        if (err_val + err_seq == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
hdl/cart_pkg.sv
hdl/address.sv
hdl/bsx_regs.sv
hdl/mcu_cfg.sv
hdl/mem_port.sv
hdl/cart_top.sv
verification/cart_tb.sv

// ==== Bender.yml ====
package:
  name: cart_map

sources:
  - files:
      - hdl/cart_pkg.sv
      - hdl/address.sv
      - hdl/bsx_regs.sv
      - hdl/mcu_cfg.sv
      - hdl/mem_port.sv
      - hdl/cart_top.sv
  - target: test
    files:
      - verification/cart_tb.sv
